/* src/dbg_cmd_pkg.sv */
package dbg_cmd_pkg;

    // command letters as typed by the host
    localparam logic [7:0] CMD_D = 8'h44;  // dump data memory
    localparam logic [7:0] CMD_I = 8'h49;  // dump instruction memory
    localparam logic [7:0] CMD_R = 8'h52;  // dump register file
    localparam logic [7:0] CMD_L = 8'h4C;  // load one instruction word

    // protocol characters
    localparam logic [7:0] CH_CR    = 8'h0D;
    localparam logic [7:0] CH_LF    = 8'h0A;
    localparam logic [7:0] CH_SP    = 8'h20;
    localparam logic [7:0] CH_COLON = 8'h3A;
    localparam logic [7:0] CH_QMARK = 8'h3F;

    // what the scanner is asked to collect
    typedef enum logic {
        SCAN_LETTER,  // first non-blank byte
        SCAN_WORD     // hex digits up to a separator
    } scan_mode_e;

    // active command at the dispatcher
    typedef enum logic [1:0] {
        CMD_IDLE,
        CMD_DUMP,  // D, I and R share one block
        CMD_LOAD,
        CMD_ERR    // unknown letter, answered with "?"
    } cmd_e;

endpackage

/* src/dbg_cpu_pkg.sv */
package dbg_cpu_pkg;

    localparam int WORD_W     = 32;  // data and address width
    localparam int DUMP_WORDS = 4;   // lines per D or I dump
    localparam int RF_WORDS   = 32;  // register file entries

    // memory targeted by a debug access
    typedef enum logic [1:0] {
        SPACE_RF,
        SPACE_DM,
        SPACE_IM
    } mem_space_e;

endpackage

/* src/dbg_mem_if.sv */
// debug access port toward the cpu memories
interface dbg_mem_if;
    import dbg_cpu_pkg::*;

    logic [WORD_W-1:0] addr;   // word index
    mem_space_e        space;
    logic [WORD_W-1:0] rdata;  // combinational, follows addr and space
    logic [WORD_W-1:0] wdata;
    logic              we;     // one-cycle write strobe

    modport master (
        output addr, space, wdata, we,
        input  rdata
    );

    modport target (
        input  addr, space, wdata, we,
        output rdata
    );

endinterface

/* src/dbg_scan_if.sv */
interface dbg_scan_if;
    import dbg_cmd_pkg::*;
    import dbg_cpu_pkg::*;

    logic              req;    // held until done
    scan_mode_e        mode;
    logic              done;   // one-cycle pulse
    logic [WORD_W-1:0] word;   // letter or hex value
    logic              empty;  // no hex digit seen
    logic              eol;    // token ended in CR

    modport user (
        output req, mode,
        input  done, word, empty, eol
    );

    modport scanner (
        input  req, mode,
        output done, word, empty, eol
    );

endinterface

/* src/hex_scan.sv */
module hex_scan (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  d_rx,
    input  logic        vld_rx,
    output logic        rdy_rx,
    dbg_scan_if.scanner scan
);
    import dbg_cmd_pkg::*;
    import dbg_cpu_pkg::*;

    logic [WORD_W-1:0] acc;  // digits collected so far
    logic              seen;
    logic              is_hex;
    logic [3:0]        nib;
    logic              xfer;
    logic              blank;
    logic              tok_end;

    // hold off while done is out, the user may switch mode next
    assign rdy_rx = scan.req && !scan.done;
    assign xfer   = vld_rx && rdy_rx;
    assign blank  = (d_rx == CH_SP) || (d_rx == CH_CR) || (d_rx == CH_LF);

    always_comb begin
        is_hex = 1'b1;
        nib    = d_rx[3:0];
        if (d_rx >= 8'h30 && d_rx <= 8'h39) begin
            nib = d_rx[3:0];
        end else if ((d_rx >= 8'h41 && d_rx <= 8'h46) || (d_rx >= 8'h61 && d_rx <= 8'h66)) begin
            nib = d_rx[3:0] + 4'd9;  // A..F and a..f
        end else begin
            is_hex = 1'b0;
        end
    end

    // letters skip line ends left over from the previous command
    always_comb begin
        if (scan.mode == SCAN_LETTER) begin
            tok_end = xfer && !blank;
        end else begin
            tok_end = xfer && !is_hex && (d_rx != CH_SP || seen);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            scan.done <= 1'b0;
            seen      <= 1'b0;
            acc       <= '0;
        end else begin
            scan.done <= tok_end;
            if (xfer && scan.mode == SCAN_WORD) begin
                if (is_hex) begin
                    acc  <= {acc[WORD_W-5:0], nib};
                    seen <= 1'b1;
                end else if (tok_end) begin
                    acc  <= '0;
                    seen <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tok_end) begin
            scan.word  <= (scan.mode == SCAN_LETTER) ? {{(WORD_W-8){1'b0}}, d_rx} : acc;
            scan.empty <= (scan.mode == SCAN_WORD) && !seen;
            scan.eol   <= (scan.mode == SCAN_WORD) && (d_rx == CH_CR);
        end
    end

    // the user must keep its request up until the result is handed over
    a_done_with_req: assert property (@(posedge clk) disable iff (rst) scan.done |-> scan.req)
        else $error("scanner done without a pending request");

endmodule

/* src/hex_print.sv */
module hex_print (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           pr_start,
    input  logic [dbg_cpu_pkg::WORD_W-1:0] pr_word,
    input  logic [7:0]                     pr_suffix,
    output logic                           pr_done,
    output logic [7:0]                     d_tx,
    output logic                           vld_tx,
    input  logic                           rdy_tx
);
    import dbg_cmd_pkg::*;
    import dbg_cpu_pkg::*;

    localparam logic [3:0] N_HEX = 4'(WORD_W / 4);

    logic [WORD_W-1:0] sh;  // top nibble goes out next
    logic [7:0]        suffix;
    logic [3:0]        cnt;
    logic [3:0]        last;
    logic              xfer;

    function automatic logic [7:0] hex_char(input logic [3:0] n);
        return (n < 4'd10) ? 8'h30 + n : 8'h37 + n;  // upper case
    endfunction

    assign xfer = vld_tx && rdy_tx;
    assign last = (suffix == CH_CR) ? N_HEX + 4'd1 : N_HEX;  // a CR suffix closes the line with LF

    always_comb begin
        if (cnt < N_HEX) begin
            d_tx = hex_char(sh[WORD_W-1 -: 4]);
        end else if (cnt == N_HEX) begin
            d_tx = suffix;
        end else begin
            d_tx = CH_LF;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_tx  <= 1'b0;
            cnt     <= '0;
            pr_done <= 1'b0;
        end else begin
            pr_done <= 1'b0;
            if (pr_start) begin
                vld_tx <= 1'b1;
                cnt    <= '0;
            end else if (xfer) begin
                cnt <= cnt + 4'd1;
                if (cnt == last) begin
                    vld_tx  <= 1'b0;
                    pr_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pr_start) begin
            sh     <= pr_word;
            suffix <= pr_suffix;
        end else if (xfer) begin
            sh <= {sh[WORD_W-5:0], 4'h0};
        end
    end

    // a stalled byte stays offered unchanged
    a_tx_hold: assert property (@(posedge clk) disable iff (rst)
        vld_tx && !rdy_tx |=> vld_tx && $stable(d_tx))
        else $error("d_tx changed under back-pressure");

endmodule

/* src/dcp_dump.sv */
module dcp_dump (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start,
    input  dbg_cpu_pkg::mem_space_e        space,
    output logic                           done,
    dbg_scan_if.user                       scan,
    dbg_mem_if.master                      mem,
    output logic                           pr_start,
    output logic [dbg_cpu_pkg::WORD_W-1:0] pr_word,
    output logic [7:0]                     pr_suffix,
    input  logic                           pr_done
);
    import dbg_cmd_pkg::*;
    import dbg_cpu_pkg::*;

    localparam int CNT_W = $clog2(RF_WORDS + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_SCAN,       // optional start address
        S_ADDR,       // kick off the address print
        S_ADDR_WAIT,
        S_DATA_WAIT
    } state_e;

    state_e            state;
    mem_space_e        sp;
    logic [WORD_W-1:0] idx;      // current word index
    logic [WORD_W-1:0] next_dm;  // where a bare D continues
    logic [WORD_W-1:0] next_im;
    logic [CNT_W-1:0]  left;     // lines still to print

    assign scan.req  = (state == S_SCAN);
    assign scan.mode = SCAN_WORD;

    assign mem.addr  = idx;
    assign mem.space = sp;
    assign mem.wdata = '0;
    assign mem.we    = 1'b0;  // read only

    // data print follows straight on the done of the address print
    assign pr_start  = (state == S_ADDR) || (state == S_ADDR_WAIT && pr_done);
    assign pr_word   = (state == S_ADDR) ? idx : mem.rdata;
    assign pr_suffix = (state == S_ADDR) ? CH_COLON : CH_CR;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            sp      <= SPACE_RF;
            idx     <= '0;
            left    <= '0;
            done    <= 1'b0;
            next_dm <= '0;
            next_im <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        sp <= space;
                        if (space == SPACE_RF) begin  // R takes no argument
                            idx   <= '0;
                            left  <= CNT_W'(RF_WORDS);
                            state <= S_ADDR;
                        end else begin
                            state <= S_SCAN;
                        end
                    end
                end
                S_SCAN: begin
                    if (scan.done) begin
                        if (scan.empty) begin
                            idx <= (sp == SPACE_DM) ? next_dm : next_im;
                        end else begin
                            idx <= scan.word;
                        end
                        left  <= CNT_W'(DUMP_WORDS);
                        state <= S_ADDR;
                    end
                end
                S_ADDR: state <= S_ADDR_WAIT;
                S_ADDR_WAIT: begin
                    if (pr_done) state <= S_DATA_WAIT;
                end
                S_DATA_WAIT: begin
                    if (pr_done) begin
                        idx  <= idx + 1'b1;
                        left <= left - 1'b1;
                        if (left == CNT_W'(1)) begin
                            state <= S_IDLE;
                            done  <= 1'b1;
                            if (sp == SPACE_DM) next_dm <= idx + 1'b1;
                            if (sp == SPACE_IM) next_im <= idx + 1'b1;
                        end else begin
                            state <= S_ADDR;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

/* src/dcp_load.sv */
module dcp_load (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    output logic      done,
    dbg_scan_if.user  scan,
    dbg_mem_if.master mem
);
    import dbg_cmd_pkg::*;
    import dbg_cpu_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA
    } state_e;

    state_e            state;
    logic [WORD_W-1:0] waddr;
    logic [WORD_W-1:0] wword;

    // request stays up across both tokens
    assign scan.req  = (state != S_IDLE);
    assign scan.mode = SCAN_WORD;

    assign mem.addr  = waddr;
    assign mem.space = SPACE_IM;
    assign mem.wdata = wword;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= S_IDLE;
            done   <= 1'b0;
            mem.we <= 1'b0;
        end else begin
            done   <= 1'b0;
            mem.we <= 1'b0;
            case (state)
                S_IDLE: if (start) state <= S_ADDR;
                S_ADDR: begin
                    if (scan.done) begin
                        if (scan.empty || scan.eol) begin  // no data word on this line
                            state <= S_IDLE;
                            done  <= 1'b1;
                        end else begin
                            state <= S_DATA;
                        end
                    end
                end
                S_DATA: begin
                    if (scan.done) begin
                        mem.we <= !scan.empty;
                        state  <= S_IDLE;
                        done   <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (scan.done && state == S_ADDR) waddr <= scan.word;
        if (scan.done && state == S_DATA) wword <= scan.word;
    end

    // the dispatcher starts a load only once the previous one has finished
    a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> state == S_IDLE)
        else $error("load started while the previous one is still running");

endmodule

/* src/dcp.sv */
module dcp (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [7:0]                     d_rx,
    input  logic                           vld_rx,
    output logic                           rdy_rx,
    output logic [7:0]                     d_tx,
    output logic                           vld_tx,
    input  logic                           rdy_tx,
    output logic [dbg_cpu_pkg::WORD_W-1:0] addr,
    input  logic [dbg_cpu_pkg::WORD_W-1:0] dout_rf,
    input  logic [dbg_cpu_pkg::WORD_W-1:0] dout_dm,
    input  logic [dbg_cpu_pkg::WORD_W-1:0] dout_im,
    output logic [dbg_cpu_pkg::WORD_W-1:0] din,
    output logic                           we_im
);
    import dbg_cmd_pkg::*;
    import dbg_cpu_pkg::*;

    dbg_scan_if scan_hw ();
    dbg_scan_if scan_dump ();
    dbg_scan_if scan_load ();
    dbg_mem_if  mem_dump ();
    dbg_mem_if  mem_load ();

    cmd_e              cmd_q;
    logic [7:0]        letter;
    logic              letter_done;
    logic              start_dump;
    logic              start_load;
    mem_space_e        dump_space;
    logic              dump_done;
    logic              load_done;
    logic              pr_start;
    logic [WORD_W-1:0] pr_word;
    logic [7:0]        pr_suffix;
    logic              pr_done;
    logic [7:0]        pr_d;
    logic              pr_vld;
    logic [1:0]        err_cnt;  // position in "?" CR LF
    logic [7:0]        err_byte;

    assign letter      = scan_hw.word[7:0];
    assign letter_done = (cmd_q == CMD_IDLE) && scan_hw.done;
    assign start_dump  = letter_done && (letter == CMD_D || letter == CMD_I || letter == CMD_R);
    assign start_load  = letter_done && (letter == CMD_L);

    always_comb begin
        case (letter)
            CMD_D:   dump_space = SPACE_DM;
            CMD_I:   dump_space = SPACE_IM;
            default: dump_space = SPACE_RF;
        endcase
    end

    // dispatcher
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_q   <= CMD_IDLE;
            err_cnt <= '0;
        end else begin
            case (cmd_q)
                CMD_IDLE: begin
                    if (start_dump) begin
                        cmd_q <= CMD_DUMP;
                    end else if (start_load) begin
                        cmd_q <= CMD_LOAD;
                    end else if (letter_done) begin
                        cmd_q   <= CMD_ERR;
                        err_cnt <= '0;
                    end
                end
                CMD_DUMP: if (dump_done) cmd_q <= CMD_IDLE;
                CMD_LOAD: if (load_done) cmd_q <= CMD_IDLE;
                default: begin
                    if (rdy_tx) begin
                        err_cnt <= err_cnt + 2'd1;
                        if (err_cnt == 2'd2) cmd_q <= CMD_IDLE;
                    end
                end
            endcase
        end
    end

    always_comb begin
        case (err_cnt)
            2'd0:    err_byte = CH_QMARK;
            2'd1:    err_byte = CH_CR;
            default: err_byte = CH_LF;
        endcase
    end

    // scanner belongs to the dispatcher while idle
    always_comb begin
        case (cmd_q)
            CMD_IDLE: begin
                scan_hw.req  = 1'b1;
                scan_hw.mode = SCAN_LETTER;
            end
            CMD_DUMP: begin
                scan_hw.req  = scan_dump.req;
                scan_hw.mode = scan_dump.mode;
            end
            CMD_LOAD: begin
                scan_hw.req  = scan_load.req;
                scan_hw.mode = scan_load.mode;
            end
            default: begin
                scan_hw.req  = 1'b0;
                scan_hw.mode = SCAN_LETTER;
            end
        endcase
    end

    assign scan_dump.done  = scan_hw.done && (cmd_q == CMD_DUMP);
    assign scan_dump.word  = scan_hw.word;
    assign scan_dump.empty = scan_hw.empty;
    assign scan_dump.eol   = scan_hw.eol;
    assign scan_load.done  = scan_hw.done && (cmd_q == CMD_LOAD);
    assign scan_load.word  = scan_hw.word;
    assign scan_load.empty = scan_hw.empty;
    assign scan_load.eol   = scan_hw.eol;

    // memory port
    always_comb begin
        case (mem_dump.space)
            SPACE_DM: mem_dump.rdata = dout_dm;
            SPACE_IM: mem_dump.rdata = dout_im;
            default:  mem_dump.rdata = dout_rf;
        endcase
    end
    assign mem_load.rdata = dout_im;  // old word at the load address

    always_comb begin
        if (cmd_q == CMD_LOAD) begin
            addr  = mem_load.addr;
            din   = mem_load.wdata;
            we_im = mem_load.we && (mem_load.space == SPACE_IM);
        end else begin
            addr  = mem_dump.addr;
            din   = mem_dump.wdata;
            we_im = mem_dump.we && (mem_dump.space == SPACE_IM);
        end
    end

    // transmit switch, printer is quiet during the error reply
    assign d_tx   = (cmd_q == CMD_ERR) ? err_byte : pr_d;
    assign vld_tx = (cmd_q == CMD_ERR) || pr_vld;

    hex_scan u_scan (
        .clk    (clk),
        .rst    (rst),
        .d_rx   (d_rx),
        .vld_rx (vld_rx),
        .rdy_rx (rdy_rx),
        .scan   (scan_hw)
    );

    hex_print u_print (
        .clk       (clk),
        .rst       (rst),
        .pr_start  (pr_start),
        .pr_word   (pr_word),
        .pr_suffix (pr_suffix),
        .pr_done   (pr_done),
        .d_tx      (pr_d),
        .vld_tx    (pr_vld),
        .rdy_tx    (rdy_tx)
    );

    dcp_dump u_dump (
        .clk       (clk),
        .rst       (rst),
        .start     (start_dump),
        .space     (dump_space),
        .done      (dump_done),
        .scan      (scan_dump),
        .mem       (mem_dump),
        .pr_start  (pr_start),
        .pr_word   (pr_word),
        .pr_suffix (pr_suffix),
        .pr_done   (pr_done)
    );

    dcp_load u_load (
        .clk   (clk),
        .rst   (rst),
        .start (start_load),
        .done  (load_done),
        .scan  (scan_load),
        .mem   (mem_load)
    );

    // dump printing, load scanning and the error reply never overlap
    a_one_active: assert property (@(posedge clk) disable iff (rst)
        $onehot0({pr_vld || scan_dump.req, scan_load.req || mem_load.we, cmd_q == CMD_ERR}))
        else $error("more than one command active");

endmodule

/* tests/tb_dcp.sv */
module tb_dcp;
    timeunit 1ns;
    timeprecision 1ps;

    import dbg_cmd_pkg::*;
    import dbg_cpu_pkg::*;

    // ~1300 reply bytes at 3/4 ready plus the typed commands, times a wide margin
    localparam int MAX_CYCLES = 20000;

    logic              clk;
    logic              rst;
    logic [7:0]        d_rx;
    logic              vld_rx;
    logic              rdy_rx;
    logic [7:0]        d_tx;
    logic              vld_tx;
    logic              rdy_tx;
    logic [WORD_W-1:0] addr;
    logic [WORD_W-1:0] dout_rf;
    logic [WORD_W-1:0] dout_dm;
    logic [WORD_W-1:0] dout_im;
    logic [WORD_W-1:0] din;
    logic              we_im;

    logic [WORD_W-1:0] rf_mem [0:31];
    logic [WORD_W-1:0] dm_mem [0:255];
    logic [WORD_W-1:0] im_mem [0:255];

    logic [7:0]        rx_q [$];   // bytes seen on d_tx
    logic [7:0]        exp_q [$];  // bytes the reply should have
    int                seed = 90093;
    int                errs;
    int                passed;
    int                failed;
    int                cycles;
    int                we_cnt;
    logic [WORD_W-1:0] w_addr;     // last write seen on the port
    logic [WORD_W-1:0] w_data;

    always #20 clk = ~clk;

    // cpu memory models, reads are combinational
    assign dout_rf = rf_mem[addr[4:0]];
    assign dout_dm = dm_mem[addr[7:0]];
    assign dout_im = im_mem[addr[7:0]];

    always @(posedge clk) begin
        if (we_im) begin
            im_mem[addr[7:0]] <= din;
            w_addr            <= addr;
            w_data            <= din;
            we_cnt            <= we_cnt + 1;
        end
    end

    dcp u_dcp (
        .clk     (clk),
        .rst     (rst),
        .d_rx    (d_rx),
        .vld_rx  (vld_rx),
        .rdy_rx  (rdy_rx),
        .d_tx    (d_tx),
        .vld_tx  (vld_tx),
        .rdy_tx  (rdy_tx),
        .addr    (addr),
        .dout_rf (dout_rf),
        .dout_dm (dout_dm),
        .dout_im (dout_im),
        .din     (din),
        .we_im   (we_im)
    );

    // host side typing, one byte per accepted handshake, closed by CR
    task automatic send_line(input string s);
        for (int i = 0; i <= s.len(); i++) begin
            d_rx   = (i < s.len()) ? s[i] : CH_CR;
            vld_rx = 1'b1;
            while (!rdy_rx) begin
                @(posedge clk);
                #2;
            end
            @(posedge clk);
            #2;
        end
        vld_rx = 1'b0;
    endtask

    task automatic collect(input int n);
        logic       take;
        logic [7:0] b;
        rx_q.delete();
        while (rx_q.size() < n) begin
            rdy_tx = (($random(seed) & 3) != 0);  // random back-pressure
            take   = vld_tx && rdy_tx;
            b      = d_tx;
            @(posedge clk);
            #2;
            if (take) rx_q.push_back(b);
        end
        rdy_tx = 1'b0;
    endtask

    function automatic void push_hex(input logic [WORD_W-1:0] w);
        logic [3:0] nib;
        for (int i = 7; i >= 0; i--) begin
            nib = w[i*4 +: 4];
            exp_q.push_back((nib < 4'd10) ? 8'h30 + nib : 8'h41 + nib - 8'd10);
        end
    endfunction

    // one line per word: index, colon, data, CR LF
    function automatic void expect_dump(input byte kind, input int start, input int count);
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] d;
        for (int k = 0; k < count; k++) begin
            a = start + k;
            if (kind == "D") d = dm_mem[a[7:0]];
            else if (kind == "I") d = im_mem[a[7:0]];
            else d = rf_mem[a[4:0]];
            push_hex(a);
            exp_q.push_back(CH_COLON);
            push_hex(d);
            exp_q.push_back(CH_CR);
            exp_q.push_back(CH_LF);
        end
    endfunction

    task automatic exchange(input string cmd);
        int n;
        n = exp_q.size();
        fork
            send_line(cmd);
            collect(n);
        join
        for (int i = 0; i < n; i++) begin
            assert (rx_q[i] == exp_q[i]) else begin
                $display("** Error: d_tx byte %0d of '%s' expected 0x%02h got 0x%02h",
                         i, cmd, exp_q[i], rx_q[i]);
                errs++;
            end
        end
        // the reply is over once the scanner takes letters again
        while (!rdy_rx && !vld_tx) begin
            @(posedge clk);
            #2;
        end
        assert (!vld_tx) else begin
            $display("reply to '%s' goes on past the expected %0d bytes", cmd, n);
            errs++;
        end
    endtask

    task automatic dump_check(input string cmd, input byte kind, input int start,
                              input int count);
        exp_q.delete();
        expect_dump(kind, start, count);
        exchange(cmd);
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errs == errs_before) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d check(s) failed", name, errs - errs_before);
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = errs;
        assert (rdy_rx === 1'b1) else begin
            $display("** Error: rdy_rx expected 0x1 got 0x%0h", rdy_rx);
            errs++;
        end
        assert (vld_tx === 1'b0) else begin
            $display("** Error: vld_tx expected 0x0 got 0x%0h", vld_tx);
            errs++;
        end
        assert (we_im === 1'b0) else begin
            $display("** Error: we_im expected 0x0 got 0x%0h", we_im);
            errs++;
        end
        report_test("reset_state", e0);
    endtask

    task automatic test_dumps();
        int e0;
        e0 = errs;
        dump_check("D 10", "D", 'h10, DUMP_WORDS);
        dump_check("D", "D", 'h14, DUMP_WORDS);       // continues after 0x13
        dump_check("I 0", "I", 0, DUMP_WORDS);
        dump_check("I", "I", DUMP_WORDS, DUMP_WORDS);
        dump_check("D", "D", 'h18, DUMP_WORDS);       // dm address untouched by I
        report_test("dump_continue", e0);
    endtask

    task automatic test_regs();
        int e0;
        e0 = errs;
        dump_check("R", "R", 0, RF_WORDS);
        report_test("register_dump", e0);
    endtask

    task automatic test_load();
        int e0;
        int cnt0;
        e0   = errs;
        cnt0 = we_cnt;
        send_line("L 5 DEADBEEF");
        wait (we_cnt != cnt0);
        repeat (3) @(posedge clk);
        #2;
        assert (we_cnt == cnt0 + 1) else begin
            $display("we_im was high for %0d cycles instead of one", we_cnt - cnt0);
            errs++;
        end
        assert (w_addr == 32'h5) else begin
            $display("** Error: addr expected 0x00000005 got 0x%08h", w_addr);
            errs++;
        end
        assert (w_data == 32'hDEADBEEF) else begin
            $display("** Error: din expected 0xdeadbeef got 0x%08h", w_data);
            errs++;
        end
        exp_q.delete();
        push_hex(32'h5);
        exp_q.push_back(CH_COLON);
        push_hex(32'hDEADBEEF);  // the word just loaded
        exp_q.push_back(CH_CR);
        exp_q.push_back(CH_LF);
        expect_dump("I", 6, DUMP_WORDS - 1);
        exchange("I 5");
        report_test("load_word", e0);
    endtask

    task automatic test_unknown();
        int e0;
        e0 = errs;
        exp_q.delete();
        exp_q.push_back(CH_QMARK);
        exp_q.push_back(CH_CR);
        exp_q.push_back(CH_LF);
        exchange("X");
        dump_check("D 20", "D", 'h20, DUMP_WORDS);  // dispatcher recovered
        report_test("unknown_letter", e0);
    endtask

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        clk    = 1'b0;
        rst    = 1'b1;
        d_rx   = '0;
        vld_rx = 1'b0;
        rdy_tx = 1'b0;
        errs   = 0;
        passed = 0;
        failed = 0;
        we_cnt = 0;
        w_addr = '0;
        w_data = '0;
        for (int i = 0; i < 32; i++) rf_mem[i] = $random(seed);
        for (int i = 0; i < 256; i++) begin
            dm_mem[i] = $random(seed);
            im_mem[i] = $random(seed);
        end
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        test_reset();
        test_dumps();
        test_regs();
        test_load();
        test_unknown();

        $display("tests passed %0d, failed %0d, checks failed %0d", passed, failed, errs);
        if (errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* dcp_debug.f */
src/dbg_cmd_pkg.sv
src/dbg_cpu_pkg.sv
src/dbg_mem_if.sv
src/dbg_scan_if.sv
src/hex_scan.sv
src/hex_print.sv
src/dcp_dump.sv
src/dcp_load.sv
src/dcp.sv
tests/tb_dcp.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps --top-module tb_dcp \
    -f dcp_debug.f -o vtb_dcp > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/vtb_dcp > sim.log 2>&1
! grep -q "STATUS: FAIL" sim.log && grep -q "STATUS: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
